/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fetch_stage
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* common/fetch_pkg.sv */
/*
 * fetch stage shared definitions
 * selector encodings, exception cause, fetched word views and bus structs
 */
`default_nettype none

package fetch_pkg;

  ////////////////////////////////////////////////////////////
  // constants
  ////////////////////////////////////////////////////////////

  // every internal interrupt is steered to this vector
  localparam logic [4:0] NMI_CAUSE = 5'd31;

  // width of the clic vector index from the csr block
  localparam int unsigned CLIC_IDX_W = 6;

  ////////////////////////////////////////////////////////////
  // selectors
  ////////////////////////////////////////////////////////////

  // source of the next fetch address
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // handler address mode, only looked at for PC_EXC
  typedef enum logic [2:0] {
    EXC_PC_EXC      = 3'd0,
    EXC_PC_IRQ      = 3'd1,
    EXC_PC_DBD      = 3'd2,
    EXC_PC_DBG_EXC  = 3'd3,
    EXC_PC_IRQ_CLIC = 3'd4,
    EXC_PC_VTABLE   = 3'd5
  } exc_pc_sel_e;

  typedef struct packed {
    logic       irq_int;
    logic [4:0] code;
  } exc_cause_t;

  ////////////////////////////////////////////////////////////
  // fetched word and pipeline entries
  ////////////////////////////////////////////////////////////

  // vector table entry, word pointer with two don't care bits
  typedef struct packed {
    logic [29:0] ptr;
    logic [1:0]  ign;
  } vtab_entry_t;

  // same bus word seen as an instruction or as a table pointer
  typedef union packed {
    logic [31:0] instr;
    vtab_entry_t vtab;
  } fetch_word_u;

  typedef struct packed {
    logic [31:0] addr;
    fetch_word_u word;
    logic        err;
  } fetch_entry_t;

  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] pc;
    logic        err;
  } id_entry_t;

  ////////////////////////////////////////////////////////////
  // core and bus side bundles
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic        pc_set;
    pc_sel_e     pc_sel;
    exc_pc_sel_e exc_pc_sel;
    exc_cause_t  exc_cause;
    logic        irq_shv;
  } pc_ctrl_t;

  typedef struct packed {
    logic [31:0]           mtvec;
    logic [31:0]           mepc;
    logic [31:0]           depc;
    logic [31:0]           mtvt;
    logic [CLIC_IDX_W-1:0] clic_idx;
  } csr_vec_t;

  typedef struct packed {
    logic        req;
    logic [31:0] addr;
  } mem_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
    logic        err;
  } mem_rsp_t;

endpackage

`default_nettype wire

/* hdl/fetch_ctrl.sv */
/*
 * fetch control
 * redirect pulse, decode handshake and the if-id valid and new flags
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  fetch_pkg::pc_ctrl_t pc_ctrl_i,
  input  logic                fetch_valid_i,
  input  logic                id_in_ready_i,
  input  logic                instr_valid_clear_i,
  output logic                branch_o,
  output logic                fetch_ready_o,
  output logic                pipe_we_o,
  output logic                instr_valid_id_o,
  output logic                instr_new_id_o,
  output logic                csr_mtvec_init_o
);

  logic valid_d;

  // every pc_set restarts the prefetcher at the selected target
  assign branch_o = pc_ctrl_i.pc_set;

  // decode pulls straight from the prefetch fifo head
  assign fetch_ready_o = id_in_ready_i;
  assign pipe_we_o     = fetch_valid_i & id_in_ready_i;

  // csr block seeds mtvec on the boot jump
  assign csr_mtvec_init_o = pc_ctrl_i.pc_set & (pc_ctrl_i.pc_sel == fetch_pkg::PC_BOOT);

  // a word loaded alongside pc_set belongs to the old stream and is squashed
  // valid then stays until decode clears it
  assign valid_d = (pipe_we_o & ~pc_ctrl_i.pc_set) | (instr_valid_id_o & ~instr_valid_clear_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_valid_id_o <= 1'b0;
      instr_new_id_o   <= 1'b0;
    end else begin
      instr_valid_id_o <= valid_d;
      // one cycle marker for each load of the if-id register
      instr_new_id_o   <= pipe_we_o;
    end
  end

endmodule

`default_nettype wire

/* hdl/fetch_stage.sv */
/*
 * instruction fetch stage
 * next pc selection, prefetch buffer and the if-id pipeline register
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
  parameter logic [31:0] DmHaltAddr      = 32'h1A11_0800,
  parameter logic [31:0] DmExceptionAddr = 32'h1A11_0808,
  parameter bit          Clic            = 1'b1,
  parameter int unsigned FifoDepth       = 3
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [31:0]         boot_addr_i,
  input  logic                req_i,
  input  fetch_pkg::pc_ctrl_t pc_ctrl_i,
  input  fetch_pkg::csr_vec_t csr_i,
  output fetch_pkg::mem_req_t instr_req_o,
  input  fetch_pkg::mem_rsp_t instr_rsp_i,
  input  logic                pmp_err_if_i,
  input  logic                id_in_ready_i,
  input  logic                instr_valid_clear_i,
  output fetch_pkg::id_entry_t id_o,
  output logic                instr_valid_id_o,
  output logic                instr_new_id_o,
  output logic [31:0]         pc_if_o,
  output logic                minhv_o,
  output logic                csr_mtvec_init_o,
  output logic                if_busy_o
);

  logic                    branch;
  logic                    pipe_we;
  logic                    fetch_valid;
  logic                    fetch_ready;
  logic [31:0]             fetch_addr;
  fetch_pkg::fetch_entry_t fetch_entry;

  // pc of the word at the prefetch output, also the pmp lookup address
  assign pc_if_o = fetch_entry.addr;

  fetch_ctrl fetch_ctrl_i (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .pc_ctrl_i           (pc_ctrl_i),
    .fetch_valid_i       (fetch_valid),
    .id_in_ready_i       (id_in_ready_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .branch_o            (branch),
    .fetch_ready_o       (fetch_ready),
    .pipe_we_o           (pipe_we),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .csr_mtvec_init_o    (csr_mtvec_init_o)
  );

  pc_select #(
    .DmHaltAddr      (DmHaltAddr),
    .DmExceptionAddr (DmExceptionAddr),
    .Clic            (Clic)
  ) pc_select_i (
    .pc_ctrl_i     (pc_ctrl_i),
    .csr_i         (csr_i),
    .boot_addr_i   (boot_addr_i),
    .fetch_entry_i (fetch_entry),
    .fetch_addr_o  (fetch_addr),
    .minhv_o       (minhv_o)
  );

  prefetch_buffer #(
    .FifoDepth (FifoDepth)
  ) prefetch_buffer_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .branch_i      (branch),
    .fetch_addr_i  (fetch_addr),
    .fetch_ready_i (fetch_ready),
    .instr_req_o   (instr_req_o),
    .instr_rsp_i   (instr_rsp_i),
    .fetch_valid_o (fetch_valid),
    .fetch_entry_o (fetch_entry),
    .busy_o        (if_busy_o)
  );

  if_id_regs if_id_regs_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .we_i          (pipe_we),
    .fetch_entry_i (fetch_entry),
    .pmp_err_if_i  (pmp_err_if_i),
    .id_o          (id_o)
  );

endmodule

`default_nettype wire

/* hdl/if_id_regs.sv */
/*
 * if-id pipeline register
 * holds the word for decode with bus and pmp errors merged
 */
`timescale 1ns/1ps
`default_nettype none

module if_id_regs (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    we_i,
  input  fetch_pkg::fetch_entry_t fetch_entry_i,
  input  logic                    pmp_err_if_i,
  output fetch_pkg::id_entry_t    id_o
);

  fetch_pkg::id_entry_t id_d;

  assign id_d.instr = fetch_entry_i.word.instr;
  assign id_d.pc    = fetch_entry_i.addr;
  // pmp check runs on the same address as the fetch output
  assign id_d.err   = fetch_entry_i.err | pmp_err_if_i;

  // frozen while decode stalls
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_o <= '0;
    end else if (we_i) begin
      id_o <= id_d;
    end
  end

endmodule

`default_nettype wire

/* hdl/pc_select.sv */
/*
 * next pc and exception pc selection
 * covers mtvec modes, debug entry, clic shv vectoring and vector table jumps
 */
`timescale 1ns/1ps
`default_nettype none

module pc_select #(
  parameter logic [31:0] DmHaltAddr      = 32'h1A11_0800,
  parameter logic [31:0] DmExceptionAddr = 32'h1A11_0808,
  parameter bit          Clic            = 1'b1
) (
  input  fetch_pkg::pc_ctrl_t     pc_ctrl_i,
  input  fetch_pkg::csr_vec_t     csr_i,
  input  logic [31:0]             boot_addr_i,
  input  fetch_pkg::fetch_entry_t fetch_entry_i,
  output logic [31:0]             fetch_addr_o,
  output logic                    minhv_o
);

  logic [4:0]  irq_vec;
  logic        shv;
  logic [31:0] shv_offs;
  logic [31:0] shv_addr;
  logic [31:0] ptr_tgt;
  logic [31:0] exc_pc;

  // internal interrupts share the nmi slot of the vectored table
  assign irq_vec = pc_ctrl_i.exc_cause.irq_int ? fetch_pkg::NMI_CAUSE
                                               : pc_ctrl_i.exc_cause.code;

  // hardware vectoring only when the core has clic and the irq asks for it
  assign shv = Clic & pc_ctrl_i.irq_shv;

  // table entry address is the 64 byte aligned mtvt plus one word per index
  assign shv_offs = {{(30 - fetch_pkg::CLIC_IDX_W){1'b0}}, csr_i.clic_idx, 2'b00};
  assign shv_addr = {csr_i.mtvt[31:6], 6'b0} + shv_offs;

  // word at the fetch output holds the handler pointer
  assign ptr_tgt = {fetch_entry_i.word.vtab.ptr, 2'b00};

  ////////////////////////////////////////////////////////////
  // exception pc
  ////////////////////////////////////////////////////////////

  always_comb begin
    unique case (pc_ctrl_i.exc_pc_sel)
      fetch_pkg::EXC_PC_EXC: begin
        exc_pc = {csr_i.mtvec[31:8], 8'h00};
      end
      fetch_pkg::EXC_PC_IRQ: begin
        // base plus four times the vector
        exc_pc = {csr_i.mtvec[31:8], 1'b0, irq_vec, 2'b00};
      end
      fetch_pkg::EXC_PC_DBD: begin
        exc_pc = DmHaltAddr;
      end
      fetch_pkg::EXC_PC_DBG_EXC: begin
        exc_pc = DmExceptionAddr;
      end
      fetch_pkg::EXC_PC_IRQ_CLIC: begin
        // shv fetches the table entry and the rest use the common clic handler
        exc_pc = shv ? shv_addr : {csr_i.mtvec[31:6], 6'b0};
      end
      fetch_pkg::EXC_PC_VTABLE: begin
        exc_pc = ptr_tgt;
      end
      default: begin
        exc_pc = {csr_i.mtvec[31:8], 8'h00};
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // next pc
  ////////////////////////////////////////////////////////////

  always_comb begin
    unique case (pc_ctrl_i.pc_sel)
      fetch_pkg::PC_BOOT: fetch_addr_o = {boot_addr_i[31:9], 9'h100};
      // jumps go through the pointer in the word at the fetch output
      fetch_pkg::PC_JUMP: fetch_addr_o = ptr_tgt;
      fetch_pkg::PC_EXC:  fetch_addr_o = exc_pc;
      fetch_pkg::PC_ERET: fetch_addr_o = csr_i.mepc;
      fetch_pkg::PC_DRET: fetch_addr_o = csr_i.depc;
      default:            fetch_addr_o = {boot_addr_i[31:9], 9'h100};
    endcase
  end

  // tells the csr block the next fetch is a table entry, not code
  assign minhv_o = pc_ctrl_i.pc_set & shv &
                   (pc_ctrl_i.pc_sel == fetch_pkg::PC_EXC) &
                   (pc_ctrl_i.exc_pc_sel == fetch_pkg::EXC_PC_IRQ_CLIC);

endmodule

`default_nettype wire

/* prefetch/fetch_fifo.sv */
/*
 * fetch fifo
 * in-order register fifo of fetched words, flushed on redirect
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_fifo #(
  parameter int unsigned FifoDepth = 3
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 clear_i,
  input  logic                                 push_i,
  input  fetch_pkg::fetch_entry_t              push_entry_i,
  input  logic                                 pop_i,
  output logic                                 valid_o,
  output fetch_pkg::fetch_entry_t              head_o,
  output logic [$clog2(FifoDepth + 1)-1:0]     free_o
);

  localparam int unsigned CntW = $clog2(FifoDepth + 1);
  localparam int unsigned PtrW = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;

  fetch_pkg::fetch_entry_t mem_q [FifoDepth];
  logic [PtrW-1:0]         wr_ptr_q;
  logic [PtrW-1:0]         rd_ptr_q;
  logic [CntW-1:0]         cnt_q;
  logic                    do_push;
  logic                    do_pop;

  // pointer step with wrap at the last slot
  function automatic logic [PtrW-1:0] ptr_inc(input logic [PtrW-1:0] ptr);
    logic [PtrW-1:0] nxt;
    nxt = (ptr == PtrW'(FifoDepth - 1)) ? '0 : ptr + 1'b1;
    return nxt;
  endfunction

  assign do_push = push_i & ~clear_i;
  assign do_pop  = pop_i & valid_o & ~clear_i;

  assign valid_o = cnt_q != '0;
  assign head_o  = mem_q[rd_ptr_q];
  assign free_o  = CntW'(FifoDepth) - cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (clear_i) begin
      // redirect empties the queue, a push in the same cycle is stale
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      cnt_q <= cnt_q + CntW'(do_push) - CntW'(do_pop);
    end
  end

  // storage slots
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_entry_i;
    end
  end

endmodule

`default_nettype wire

/* prefetch/prefetch_buffer.sv */
/*
 * prefetch buffer
 * issues word fetches ahead of decode, drops stale responses after a redirect
 */
`timescale 1ns/1ps
`default_nettype none

module prefetch_buffer #(
  parameter int unsigned FifoDepth = 3
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    req_i,
  input  logic                    branch_i,
  input  logic [31:0]             fetch_addr_i,
  input  logic                    fetch_ready_i,
  output fetch_pkg::mem_req_t     instr_req_o,
  input  fetch_pkg::mem_rsp_t     instr_rsp_i,
  output logic                    fetch_valid_o,
  output fetch_pkg::fetch_entry_t fetch_entry_o,
  output logic                    busy_o
);

  localparam int unsigned CntW = $clog2(FifoDepth + 1);

  // request side state
  logic        run_q;
  logic [29:0] addr_q;
  logic        hold_q;
  logic [29:0] hold_addr_q;
  logic [1:0]  out_q;
  logic [1:0]  out_d;

  // response side state
  logic [1:0]  disc_q;
  logic [1:0]  disc_d;
  logic [29:0] rsp_addr_q;

  logic [CntW-1:0]         fifo_free;
  logic                    new_req;
  logic                    bus_req;
  logic [29:0]             bus_addr;
  logic                    gnt;
  logic                    drop;
  logic                    push;
  fetch_pkg::fetch_entry_t push_entry;

  ////////////////////////////////////////////////////////////
  // bus requests
  ////////////////////////////////////////////////////////////

  // start a fetch only with a reserved fifo slot for every word in flight
  // nothing new in the redirect cycle, the target goes out next cycle
  assign new_req = run_q & req_i & ~hold_q & ~branch_i & (out_q != 2'd2) &
                   (32'(fifo_free) > 32'(out_q));

  // an ungranted request stays up with its address frozen
  assign bus_req  = hold_q | new_req;
  assign bus_addr = hold_q ? hold_addr_q : addr_q;
  assign gnt      = bus_req & instr_rsp_i.gnt;

  assign instr_req_o.req  = bus_req;
  assign instr_req_o.addr = {bus_addr, 2'b00};

  assign out_d = out_q + {1'b0, gnt} - {1'b0, instr_rsp_i.rvalid};

  assign busy_o = hold_q | (out_q != 2'd0);

  ////////////////////////////////////////////////////////////
  // responses
  ////////////////////////////////////////////////////////////

  assign drop = disc_q != 2'd0;
  assign push = instr_rsp_i.rvalid & ~drop;

  // on redirect every granted or still pending request becomes stale
  always_comb begin
    disc_d = disc_q;
    if (branch_i) begin
      disc_d = out_d + {1'b0, bus_req & ~gnt};
    end else if (instr_rsp_i.rvalid & drop) begin
      disc_d = disc_q - 2'd1;
    end
  end

  // responses come back in order so the tag just counts up from the target
  assign push_entry.addr       = {rsp_addr_q, 2'b00};
  assign push_entry.word.instr = instr_rsp_i.rdata;
  assign push_entry.err        = instr_rsp_i.err;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      run_q      <= 1'b0;
      addr_q     <= '0;
      hold_q     <= 1'b0;
      out_q      <= 2'd0;
      disc_q     <= 2'd0;
      rsp_addr_q <= '0;
    end else begin
      hold_q <= bus_req & ~gnt;
      out_q  <= out_d;
      disc_q <= disc_d;
      if (branch_i) begin
        // first pc_set after reset enables fetching
        run_q      <= 1'b1;
        addr_q     <= fetch_addr_i[31:2];
        rsp_addr_q <= fetch_addr_i[31:2];
      end else begin
        if (new_req) begin
          addr_q <= addr_q + 30'd1;
        end
        if (push) begin
          rsp_addr_q <= rsp_addr_q + 30'd1;
        end
      end
    end
  end

  // address of a request that missed its grant
  always_ff @(posedge clk_i) begin
    hold_addr_q <= bus_addr;
  end

  fetch_fifo #(
    .FifoDepth (FifoDepth)
  ) fetch_fifo_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (branch_i),
    .push_i       (push),
    .push_entry_i (push_entry),
    .pop_i        (fetch_ready_i),
    .valid_o      (fetch_valid_o),
    .head_o       (fetch_entry_o),
    .free_o       (fifo_free)
  );

endmodule

`default_nettype wire

/* tb.f */
common/fetch_pkg.sv
hdl/fetch_ctrl.sv
hdl/pc_select.sv
prefetch/fetch_fifo.sv
prefetch/prefetch_buffer.sv
hdl/if_id_regs.sv
hdl/fetch_stage.sv
tests/tb_fetch_memory.sv
tests/tb_fetch_stage.sv

/* tests/tb_fetch_memory.sv */
/*
 * behavioral instruction memory and pmp model
 * random grant and response latency, in-order responses, error windows
 */
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_memory #(
  parameter logic [31:0] ErrLo = 32'h0000_2000,
  parameter logic [31:0] ErrHi = 32'h0000_2010,
  parameter logic [31:0] PmpLo = 32'h0000_3000,
  parameter logic [31:0] PmpHi = 32'h0000_3010
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  fetch_pkg::mem_req_t req_i,
  input  logic [31:0]         pc_if_i,
  output fetch_pkg::mem_rsp_t rsp_o,
  output logic                pmp_err_o
);

  logic [1:0]  gnt_wait_q;
  logic        rvalid_q;
  logic [31:0] rdata_q;
  logic        err_q;
  int unsigned cycle_q;
  int unsigned last_due;
  // granted requests waiting for their response cycle
  int unsigned due_q [$];
  logic [31:0] addr_q [$];

  // memory contents, every word depends on its full address
  function automatic logic [31:0] word_at(input logic [31:0] addr);
    return (addr ^ 32'h5a5a_0000) | 32'h0000_0003;
  endfunction

  // grant after a random wait of 0 to 2 cycles
  assign rsp_o.gnt    = req_i.req && (gnt_wait_q == 2'd0);
  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;
  assign rsp_o.err    = err_q;

  // pmp looks at the word currently at the fetch output
  assign pmp_err_o = (pc_if_i >= PmpLo) && (pc_if_i < PmpHi);

  always @(posedge clk_i or negedge rst_ni) begin
    int unsigned due;
    if (!rst_ni) begin
      gnt_wait_q <= 2'd0;
      rvalid_q   <= 1'b0;
      rdata_q    <= '0;
      err_q      <= 1'b0;
      cycle_q    <= 0;
      last_due = 0;
      due_q.delete();
      addr_q.delete();
    end else begin
      cycle_q  <= cycle_q + 1;
      rvalid_q <= 1'b0;
      // oldest response first
      if ((due_q.size() != 0) && (due_q[0] <= cycle_q)) begin
        rvalid_q <= 1'b1;
        rdata_q  <= word_at(addr_q[0]);
        err_q    <= (addr_q[0] >= ErrLo) && (addr_q[0] < ErrHi);
        void'(due_q.pop_front());
        void'(addr_q.pop_front());
      end
      if (req_i.req) begin
        if (gnt_wait_q == 2'd0) begin
          // response 1 to 3 cycles later, never ahead of an older one
          due = cycle_q + 1 + ($urandom % 3);
          if (due <= last_due) begin
            due = last_due + 1;
          end
          last_due = due;
          due_q.push_back(due);
          addr_q.push_back(req_i.addr);
          gnt_wait_q <= 2'($urandom % 3);
        end else begin
          gnt_wait_q <= gnt_wait_q - 2'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* tests/tb_fetch_stage.sv */
/*
 * testbench for the fetch stage
 * table of redirects, checks the pc sequence, instructions, errors and strobes
 */
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_stage;

  localparam logic [31:0] BOOT_ADDR = 32'h0000_1000;
  localparam logic [31:0] DM_HALT   = 32'h0000_0800;
  localparam logic [31:0] DM_EXC    = 32'h0000_0808;
  localparam logic [31:0] ERR_LO    = 32'h0000_2000;
  localparam logic [31:0] ERR_HI    = 32'h0000_2010;
  localparam logic [31:0] PMP_LO    = 32'h0000_3000;
  localparam logic [31:0] PMP_HI    = 32'h0000_3010;
  localparam int unsigned SEED      = 32'h3e1a6992;
  localparam int          NROWS     = 11;
  localparam int          MAX_INSTR = 7;
  localparam int          LIMIT     = NROWS * MAX_INSTR * 40;

  typedef struct {
    fetch_pkg::pc_ctrl_t ctrl;
    fetch_pkg::csr_vec_t csr;
    bit                  hold;
    int                  n_instr;
    logic [31:0]         target;
  } row_t;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 req;
  fetch_pkg::pc_ctrl_t  pc_ctrl;
  fetch_pkg::csr_vec_t  csr;
  fetch_pkg::mem_req_t  instr_req;
  fetch_pkg::mem_rsp_t  instr_rsp;
  logic                 pmp_err;
  logic                 id_in_ready;
  logic                 valid_clear;
  fetch_pkg::id_entry_t id;
  logic                 valid_id;
  logic                 new_id;
  logic [31:0]          pc_if;
  logic                 minhv;
  logic                 mtvec_init;
  logic                 busy;

  row_t        rows [NROWS];
  bit          prev_hold;

  fetch_stage #(
    .DmHaltAddr      (DM_HALT),
    .DmExceptionAddr (DM_EXC),
    .Clic            (1'b1),
    .FifoDepth       (3)
  ) fetch_stage_i (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .boot_addr_i         (BOOT_ADDR),
    .req_i               (req),
    .pc_ctrl_i           (pc_ctrl),
    .csr_i               (csr),
    .instr_req_o         (instr_req),
    .instr_rsp_i         (instr_rsp),
    .pmp_err_if_i        (pmp_err),
    .id_in_ready_i       (id_in_ready),
    .instr_valid_clear_i (valid_clear),
    .id_o                (id),
    .instr_valid_id_o    (valid_id),
    .instr_new_id_o      (new_id),
    .pc_if_o             (pc_if),
    .minhv_o             (minhv),
    .csr_mtvec_init_o    (mtvec_init),
    .if_busy_o           (busy)
  );

  tb_fetch_memory #(
    .ErrLo (ERR_LO),
    .ErrHi (ERR_HI),
    .PmpLo (PMP_LO),
    .PmpHi (PMP_HI)
  ) memory_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_i     (instr_req),
    .pc_if_i   (pc_if),
    .rsp_o     (instr_rsp),
    .pmp_err_o (pmp_err)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // reference rules and checks
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] expect_word(input logic [31:0] addr);
    return (addr ^ 32'h5a5a_0000) | 32'h0000_0003;
  endfunction

  // bus error window or pmp window
  function automatic logic in_window(input logic [31:0] addr);
    return ((addr >= ERR_LO) && (addr < ERR_HI)) || ((addr >= PMP_LO) && (addr < PMP_HI));
  endfunction

  function automatic logic random_ready();
    return ($urandom % 4) != 0;
  endfunction

  task automatic abort_run();
    $display("TESTS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_id(input string name, input fetch_pkg::id_entry_t got,
                          input fetch_pkg::id_entry_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_addr(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  // nothing may move before the first redirect
  task automatic check_idle();
    check_flag("instr_req_o.req", instr_req.req, 1'b0);
    check_flag("instr_valid_id_o", valid_id, 1'b0);
    check_flag("instr_new_id_o", new_id, 1'b0);
    check_flag("minhv_o", minhv, 1'b0);
    check_flag("csr_mtvec_init_o", mtvec_init, 1'b0);
    check_flag("if_busy_o", busy, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////////////

  function automatic fetch_pkg::pc_ctrl_t make_ctrl(input fetch_pkg::pc_sel_e sel,
                                                    input fetch_pkg::exc_pc_sel_e esel,
                                                    input logic irq_int, input logic [4:0] code,
                                                    input logic shv);
    fetch_pkg::pc_ctrl_t c;
    c.pc_set            = 1'b1;
    c.pc_sel            = sel;
    c.exc_pc_sel        = esel;
    c.exc_cause.irq_int = irq_int;
    c.exc_cause.code    = code;
    c.irq_shv           = shv;
    return c;
  endfunction

  task automatic add_row(input int idx, input fetch_pkg::pc_ctrl_t ctrl,
                         input logic [31:0] mepc, input logic [31:0] depc,
                         input bit hold, input int n_instr, input logic [31:0] target);
    rows[idx].ctrl          = ctrl;
    // mtvec mode bits are set and the handler base ignores them
    rows[idx].csr.mtvec     = 32'h0000_4081;
    rows[idx].csr.mepc      = mepc;
    rows[idx].csr.depc      = depc;
    rows[idx].csr.mtvt      = 32'h0000_7050;
    rows[idx].csr.clic_idx  = 6'd5;
    rows[idx].hold          = hold;
    rows[idx].n_instr       = n_instr;
    rows[idx].target        = target;
  endtask

  task automatic load_table();
    // boot page offset 0x100
    add_row(0, make_ctrl(fetch_pkg::PC_BOOT, fetch_pkg::EXC_PC_EXC, 1'b0, 5'd0, 1'b0),
            32'h5004, 32'h6008, 1'b0, 6, 32'h0000_1100);
    add_row(1, make_ctrl(fetch_pkg::PC_EXC, fetch_pkg::EXC_PC_EXC, 1'b0, 5'd2, 1'b0),
            32'h5004, 32'h6008, 1'b0, 3, 32'h0000_4000);
    // base plus 4 * 3
    add_row(2, make_ctrl(fetch_pkg::PC_EXC, fetch_pkg::EXC_PC_IRQ, 1'b0, 5'd3, 1'b0),
            32'h5004, 32'h6008, 1'b0, 3, 32'h0000_400c);
    // internal irq lands on slot 31
    add_row(3, make_ctrl(fetch_pkg::PC_EXC, fetch_pkg::EXC_PC_IRQ, 1'b1, 5'd5, 1'b0),
            32'h5004, 32'h6008, 1'b0, 3, 32'h0000_407c);
    add_row(4, make_ctrl(fetch_pkg::PC_EXC, fetch_pkg::EXC_PC_IRQ_CLIC, 1'b0, 5'd7, 1'b0),
            32'h5004, 32'h6008, 1'b0, 3, 32'h0000_4080);
    // eret walks through the bus error window
    add_row(5, make_ctrl(fetch_pkg::PC_ERET, fetch_pkg::EXC_PC_EXC, 1'b0, 5'd0, 1'b0),
            32'h1ff8, 32'h6008, 1'b0, 7, 32'h0000_1ff8);
    // dret walks through the pmp window
    add_row(6, make_ctrl(fetch_pkg::PC_DRET, fetch_pkg::EXC_PC_EXC, 1'b0, 5'd0, 1'b0),
            32'h5004, 32'h2ff8, 1'b0, 7, 32'h0000_2ff8);
    add_row(7, make_ctrl(fetch_pkg::PC_EXC, fetch_pkg::EXC_PC_DBD, 1'b0, 5'd0, 1'b0),
            32'h5004, 32'h6008, 1'b0, 3, DM_HALT);
    add_row(8, make_ctrl(fetch_pkg::PC_EXC, fetch_pkg::EXC_PC_DBG_EXC, 1'b0, 5'd0, 1'b0),
            32'h5004, 32'h6008, 1'b0, 3, DM_EXC);
    // shv entry at 0x7040 + 4 * 5 and the word is kept at the fetch output
    add_row(9, make_ctrl(fetch_pkg::PC_EXC, fetch_pkg::EXC_PC_IRQ_CLIC, 1'b0, 5'd9, 1'b1),
            32'h5004, 32'h6008, 1'b1, 0, 32'h0000_7054);
    add_row(10, make_ctrl(fetch_pkg::PC_EXC, fetch_pkg::EXC_PC_VTABLE, 1'b0, 5'd9, 1'b0),
            32'h5004, 32'h6008, 1'b0, 4, expect_word(32'h0000_7054) & 32'hffff_fffc);
  endtask

  ////////////////////////////////////////////////////////////
  // drivers
  ////////////////////////////////////////////////////////////

  task automatic drive_cycle(input logic ready, input logic clear);
    @(posedge clk_i);
    pc_ctrl.pc_set <= 1'b0;
    id_in_ready    <= ready;
    valid_clear    <= clear;
  endtask

  // take n words from decode and check the sequence from the target on
  task automatic consume(input logic [31:0] target, input int n);
    logic [31:0]          pc;
    int                   got;
    logic                 clear_next;
    fetch_pkg::id_entry_t exp;
    pc         = target;
    got        = 0;
    clear_next = 1'b0;
    while (got < n) begin
      drive_cycle(random_ready(), clear_next);
      @(negedge clk_i);
      clear_next = 1'b0;
      // new without valid is a squashed old stream word
      if (new_id && valid_id) begin
        exp.instr = expect_word(pc);
        exp.pc    = pc;
        exp.err   = in_window(pc);
        check_addr("id_o.pc", id.pc, pc);
        check_id("id_o", id, exp);
        pc         = pc + 32'd4;
        got++;
        clear_next = 1'b1;
      end
    end
    drive_cycle(1'b0, 1'b1);
  endtask

  task automatic run_row(input row_t r, input bit after_hold);
    logic exp_minhv;
    exp_minhv = (r.ctrl.pc_sel == fetch_pkg::PC_EXC) &&
                (r.ctrl.exc_pc_sel == fetch_pkg::EXC_PC_IRQ_CLIC) && r.ctrl.irq_shv;
    @(posedge clk_i);
    pc_ctrl     <= r.ctrl;
    csr         <= r.csr;
    id_in_ready <= (r.hold || after_hold) ? 1'b0 : random_ready();
    valid_clear <= 1'b0;
    @(negedge clk_i);
    check_flag("minhv_o", minhv, exp_minhv);
    check_flag("csr_mtvec_init_o", mtvec_init, r.ctrl.pc_sel == fetch_pkg::PC_BOOT);
    if (r.hold) begin
      drive_cycle(1'b0, 1'b0);
      // stall decode until the table word reaches the fetch output
      do begin
        @(negedge clk_i);
      end while (pc_if !== r.target);
    end else begin
      consume(r.target, r.n_instr);
    end
  endtask

  // strobes tied to pc_set stay low in every other cycle
  always @(negedge clk_i) begin
    if (rst_ni && !pc_ctrl.pc_set) begin
      check_flag("minhv_o", minhv, 1'b0);
      check_flag("csr_mtvec_init_o", mtvec_init, 1'b0);
    end
  end

  initial begin
    repeat (LIMIT + 40) @(posedge clk_i);
    $display("timeout: run did not finish within %0d cycles", LIMIT + 40);
    abort_run();
  end

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(SEED));
    prev_hold   = 1'b0;
    rst_ni      = 1'b0;
    req         = 1'b1;
    pc_ctrl     = '0;
    csr         = '0;
    id_in_ready = 1'b0;
    valid_clear = 1'b0;
    load_table();

    repeat (10) begin
      @(negedge clk_i);
      check_idle();
    end
    @(posedge clk_i);
    rst_ni <= 1'b1;
    // req_i is high but nothing is fetched without a redirect
    repeat (5) begin
      @(negedge clk_i);
      check_idle();
    end

    for (int i = 0; i < NROWS; i++) begin
      run_row(rows[i], prev_hold);
      prev_hold = rows[i].hold;
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire
